/* verilog/median_pkg.sv */
//----------------------------------------------------------
// shared widths, kernel geometry and the sorting network
// pairing rule for the 5x5 median filter
//----------------------------------------------------------
package median_pkg;

    localparam int PIX_WIDTH   = 12;
    localparam int KERNEL_DIM  = 5;
    localparam int KERNEL_SIZE = KERNEL_DIM * KERNEL_DIM;
    localparam int CENTRE_IDX  = KERNEL_SIZE / 2;
    localparam int NET_SIZE    = 32;
    localparam int SORT_STAGES = 15;
    localparam int LINE_WIDTH  = 16;
    localparam int COL_WIDTH   = $clog2(LINE_WIDTH);
    localparam int LINE_BUFS   = KERNEL_DIM - 1;
    localparam int BUF_SEL_W   = $clog2(LINE_BUFS);
    localparam int ROW_CNT_W   = $clog2(LINE_BUFS + 1);

    typedef logic [PIX_WIDTH-1:0] pix_t;
    // raster order, row 0 is the oldest line
    typedef pix_t [KERNEL_SIZE-1:0] kernel_t;

    // true when entry a is the low end of a comparator in layer (p, k)
    function automatic bit batcher_low(input int a, input int p, input int k);
        int ofs;
        ofs = k % p;
        batcher_low = (a >= ofs) && (((a - ofs) % (2 * k)) < k) &&
                      ((a / (2 * p)) == ((a + k) / (2 * p))) && (a + k < KERNEL_SIZE);
    endfunction

    // entries past KERNEL_SIZE are treated as absent
    function automatic int batcher_partner(input int stage, input int idx);
        int p;
        int k;
        int cnt;
        p = 1;
        k = 1;
        cnt = 0;
        for (int lp = 0; lp < $clog2(NET_SIZE); lp++) begin
            for (int lk = lp; lk >= 0; lk--) begin
                if (cnt == stage) begin
                    p = 1 << lp;
                    k = 1 << lk;
                end
                cnt++;
            end
        end
        batcher_partner = idx;
        if (batcher_low(idx, p, k))
            batcher_partner = idx + k;
        else if (idx >= k && batcher_low(idx - k, p, k))
            batcher_partner = idx - k;
    endfunction

endpackage

/* verilog/window_builder.sv */
//----------------------------------------------------------
// turns the pixel stream into 5x5 neighbourhoods using four
// line memories in a ring and a register window
//----------------------------------------------------------
`timescale 1ns/10ps

module window_builder import median_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,

    input  pix_t    di_i,
    input  logic    de_i,
    input  logic    vs_i,

    output kernel_t win_o,
    output pix_t    centre_o,
    output logic    win_valid_o,
    output logic    win_vs_o
);

    logic [COL_WIDTH-1:0] col_cnt;
    // saturates once four full lines are stored
    logic [ROW_CNT_W-1:0] line_cnt;
    // memory that takes the current line
    logic [BUF_SEL_W-1:0] wr_sel;
    logic                 line_end;
    logic                 interior;

    pix_t    line_mem [LINE_BUFS][LINE_WIDTH];
    pix_t    tap [KERNEL_DIM];
    kernel_t win_q;

    assign line_end = (col_cnt == COL_WIDTH'(LINE_WIDTH - 1));
    assign interior = (line_cnt == ROW_CNT_W'(LINE_BUFS)) &&
                      (col_cnt >= COL_WIDTH'(LINE_BUFS));

    //----------------------------------------------------------
    // column of new pixels, one per window row
    //----------------------------------------------------------
    // row k reads line r-4+k, so the oldest line sits in wr_sel
    always_comb begin
        logic [BUF_SEL_W-1:0] sel;
        sel = wr_sel;
        for (int r = 0; r < LINE_BUFS; r++) begin
            sel = wr_sel + BUF_SEL_W'(r);
            tap[r] = line_mem[sel][col_cnt];
        end
        tap[KERNEL_DIM-1] = di_i;
    end

    // old value is read above before the current line overwrites it
    always_ff @(posedge clk) begin
        if (de_i) begin
            line_mem[wr_sel][col_cnt] <= di_i;
        end
    end

    //----------------------------------------------------------
    // 5x5 shift window
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (de_i) begin
            for (int r = 0; r < KERNEL_DIM; r++) begin
                for (int c = 0; c < KERNEL_DIM - 1; c++) begin
                    win_q[r*KERNEL_DIM+c] <= win_q[r*KERNEL_DIM+c+1];
                end
                win_q[r*KERNEL_DIM+KERNEL_DIM-1] <= tap[r];
            end
        end
    end

    //----------------------------------------------------------
    // position counters
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_cnt  <= '0;
            line_cnt <= '0;
            wr_sel   <= '0;
        end else if (vs_i) begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end else if (de_i) begin
            if (line_end) begin
                col_cnt <= '0;
                // ring of four, wraps by width
                wr_sel  <= wr_sel + 1'b1;
                if (line_cnt != ROW_CNT_W'(LINE_BUFS)) begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // strobes, one cycle after the accepted pixel
    always_ff @(posedge clk) begin
        if (rst_i) begin
            win_valid_o <= 1'b0;
            win_vs_o    <= 1'b0;
        end else begin
            win_valid_o <= de_i && interior;
            win_vs_o    <= vs_i;
        end
    end

    assign win_o    = win_q;
    // centre is line r-2, column c-2
    assign centre_o = win_q[CENTRE_IDX];

endmodule

/* verilog/sort_stage.sv */
//----------------------------------------------------------
// one registered compare-exchange layer of the odd-even
// merge sort, the layer picked by STAGE_IDX
//----------------------------------------------------------
`timescale 1ns/10ps

module sort_stage import median_pkg::*; #(
    parameter int STAGE_IDX = 0
) (
    input  logic    clk,
    input  logic    rst_i,

    input  kernel_t data_i,
    input  pix_t    centre_i,
    input  logic    valid_i,
    input  logic    vs_i,

    output kernel_t data_o,
    output pix_t    centre_o,
    output logic    valid_o,
    output logic    vs_o
);

    kernel_t exch;

    //----------------------------------------------------------
    // compare-exchange network for this layer
    //----------------------------------------------------------
    for (genvar g = 0; g < KERNEL_SIZE; g++) begin : entry_g
        localparam int PARTNER = batcher_partner(STAGE_IDX, g);

        if (PARTNER > g) begin : lo_g
            // low end keeps the smaller value
            assign exch[g] = (data_i[PARTNER] < data_i[g]) ? data_i[PARTNER] : data_i[g];
        end else if (PARTNER < g) begin : hi_g
            assign exch[g] = (data_i[PARTNER] < data_i[g]) ? data_i[g] : data_i[PARTNER];
        end else begin : pass_g
            assign exch[g] = data_i[g];
        end
    end

    //----------------------------------------------------------
    // pipeline register
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o   <= exch;
            centre_o <= centre_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            vs_o    <= 1'b0;
        end else begin
            valid_o <= valid_i;
            vs_o    <= vs_i;
        end
    end

endmodule

/* verilog/median_output.sv */
//----------------------------------------------------------
// output stage, selects the median or the raw centre pixel
// by a mode latched once per frame
//----------------------------------------------------------
`timescale 1ns/10ps

module median_output import median_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,

    input  kernel_t sorted_i,
    input  pix_t    centre_i,
    input  logic    valid_i,
    input  logic    vs_i,
    input  logic    bypass_i,

    output pix_t    do_o,
    output logic    de_o,
    output logic    vs_o
);

    // frame mode, high passes the centre pixel
    logic bypass_q;

    // vs_i here is the frame start after the sort pipeline, so every
    // pixel of the previous frame has already left when the mode moves
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bypass_q <= 1'b0;
        end else if (vs_i) begin
            bypass_q <= bypass_i;
        end
    end

    //----------------------------------------------------------
    // output registers
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (valid_i) begin
            if (bypass_q) begin
                do_o <= centre_i;
            end else begin
                do_o <= sorted_i[CENTRE_IDX];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_o <= 1'b0;
            vs_o <= 1'b0;
        end else begin
            de_o <= valid_i;
            vs_o <= vs_i;
        end
    end

endmodule

/* verilog/median_filter_5x5.sv */
//----------------------------------------------------------
// streaming 5x5 median filter, X by Y in and (X-4) by (Y-4)
// out, 17 cycles from an accepted pixel to de_o
//----------------------------------------------------------
`timescale 1ns/10ps

module median_filter_5x5 import median_pkg::*; (
    input  logic clk,
    input  logic rst_i,

    input  pix_t di_i,
    input  logic de_i,
    input  logic vs_i,
    input  logic bypass_i,

    output pix_t do_o,
    output logic de_o,
    output logic vs_o
);

    // link 0 is the window, link SORT_STAGES is fully sorted
    kernel_t stage_data   [SORT_STAGES+1];
    pix_t    stage_centre [SORT_STAGES+1];
    logic    stage_valid  [SORT_STAGES+1];
    logic    stage_vs     [SORT_STAGES+1];

    window_builder u_window (
        .clk         (clk),
        .rst_i       (rst_i),
        .di_i        (di_i),
        .de_i        (de_i),
        .vs_i        (vs_i),
        .win_o       (stage_data[0]),
        .centre_o    (stage_centre[0]),
        .win_valid_o (stage_valid[0]),
        .win_vs_o    (stage_vs[0])
    );

    for (genvar s = 0; s < SORT_STAGES; s++) begin : sort_g
        sort_stage #(
            .STAGE_IDX (s)
        ) u_stage (
            .clk      (clk),
            .rst_i    (rst_i),
            .data_i   (stage_data[s]),
            .centre_i (stage_centre[s]),
            .valid_i  (stage_valid[s]),
            .vs_i     (stage_vs[s]),
            .data_o   (stage_data[s+1]),
            .centre_o (stage_centre[s+1]),
            .valid_o  (stage_valid[s+1]),
            .vs_o     (stage_vs[s+1])
        );
    end

    median_output u_output (
        .clk      (clk),
        .rst_i    (rst_i),
        .sorted_i (stage_data[SORT_STAGES]),
        .centre_i (stage_centre[SORT_STAGES]),
        .valid_i  (stage_valid[SORT_STAGES]),
        .vs_i     (stage_vs[SORT_STAGES]),
        .bypass_i (bypass_i),
        .do_o     (do_o),
        .de_o     (de_o),
        .vs_o     (vs_o)
    );

endmodule

/* tests/median_filter_props.sv */
//----------------------------------------------------------
// timing assertions for the median filter, bound to the top
//----------------------------------------------------------
`timescale 1ns/10ps

module median_filter_props (
    input  logic clk,
    input  logic rst_i,
    input  logic win_valid_i,
    input  logic in_vs_i,
    input  logic out_de_i,
    input  logic out_vs_i
);

    // cycles since reset was released, saturating
    logic [5:0] since_rst;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            since_rst <= '0;
        end else if (since_rst != 6'h3f) begin
            since_rst <= since_rst + 1'b1;
        end
    end

    // window valid is one cycle after the accepted de_i
    de_latency_a: assert property (@(posedge clk) disable iff (rst_i)
        $past(win_valid_i, 16) |-> out_de_i)
        else $error("de_o missing 17 cycles after an accepted pixel");

    de_source_a: assert property (@(posedge clk) disable iff (rst_i)
        out_de_i |-> $past(win_valid_i, 16))
        else $error("de_o without an accepted pixel 17 cycles before");

    vs_latency_a: assert property (@(posedge clk) disable iff (rst_i)
        $past(in_vs_i, 17) |-> out_vs_i)
        else $error("vs_o missing 17 cycles after vs_i");

    vs_source_a: assert property (@(posedge clk) disable iff (rst_i)
        out_vs_i |-> $past(in_vs_i, 17))
        else $error("vs_o without vs_i 17 cycles before");

    quiet_after_reset_a: assert property (@(posedge clk) disable iff (rst_i)
        (since_rst < 6'd17) |-> !out_de_i)
        else $error("de_o while the pipeline is still empty");

endmodule

bind median_filter_5x5 median_filter_props u_props (
    .clk         (clk),
    .rst_i       (rst_i),
    .win_valid_i (stage_valid[0]),
    .in_vs_i     (vs_i),
    .out_de_i    (de_o),
    .out_vs_i    (vs_o)
);

/* tests/median_filter_tb.sv */
//----------------------------------------------------------
// testbench for the 5x5 median filter, random frames checked
// against a sorting model in the testbench
//----------------------------------------------------------
`timescale 1ns/10ps

module median_filter_tb import median_pkg::*; ();

    localparam int CLK_HALF      = 4;
    localparam int DRIVE_DLY     = 1;
    localparam int FRAME_H       = 10;
    localparam int FRAMES        = 5;
    localparam int VS_IDLE       = 20;
    localparam int LATENCY       = 17;
    localparam int EDGE          = KERNEL_DIM - 1;
    localparam int PIX_PER_FRAME = (LINE_WIDTH - EDGE) * (FRAME_H - EDGE);
    // worst case has a gap after every pixel
    localparam int INPUT_CYCLES  = FRAMES * (1 + VS_IDLE + 2 * LINE_WIDTH * FRAME_H) + 2;
    localparam int TIMEOUT       = 2 * INPUT_CYCLES + 100;

    logic clk = 1'b0;
    logic rst_i;
    pix_t di_i;
    logic de_i;
    logic vs_i;
    logic bypass_i;
    pix_t do_o;
    logic de_o;
    logic vs_o;

    int seed;
    int cyc = 0;
    int errors = 0;
    int checked = 0;
    int frame_cnt = 0;
    int frames_seen = 0;
    bit done;

    // 0 random, 1 all zero, 2 all maximum, 3 small values with ties
    int pattern_of [FRAMES] = '{0, 1, 2, 0, 3};
    bit bypass_of  [FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    bit toggle_of  [FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    pix_t frame_pix [FRAME_H][LINE_WIDTH];
    pix_t exp_q [$];
    int   de_cyc_q [$];
    int   vs_cyc_q [$];

    median_filter_5x5 UUT (
        .clk      (clk),
        .rst_i    (rst_i),
        .di_i     (di_i),
        .de_i     (de_i),
        .vs_i     (vs_i),
        .bypass_i (bypass_i),
        .do_o     (do_o),
        .de_o     (de_o),
        .vs_o     (vs_o)
    );

    always #CLK_HALF clk = ~clk;

    //----------------------------------------------------------
    // reference model
    //----------------------------------------------------------
    function automatic pix_t median_of(input int r, input int c);
        pix_t vals [KERNEL_SIZE];
        pix_t tmp;
        int n;
        int j;
        n = 0;
        for (int dr = 0; dr < KERNEL_DIM; dr++) begin
            for (int dc = 0; dc < KERNEL_DIM; dc++) begin
                vals[n] = frame_pix[r-EDGE+dr][c-EDGE+dc];
                n++;
            end
        end
        // insertion sort, ascending
        for (int i = 1; i < KERNEL_SIZE; i++) begin
            tmp = vals[i];
            j = i;
            while (j > 0 && vals[j-1] > tmp) begin
                vals[j] = vals[j-1];
                j--;
            end
            vals[j] = tmp;
        end
        return vals[CENTRE_IDX];
    endfunction

    task automatic build_frame(input int pattern);
        int rnd;
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < LINE_WIDTH; c++) begin
                rnd = $random(seed);
                case (pattern)
                    1: frame_pix[r][c] = '0;
                    2: frame_pix[r][c] = '1;
                    3: frame_pix[r][c] = {9'd0, rnd[2:0]};
                    default: frame_pix[r][c] = rnd[PIX_WIDTH-1:0];
                endcase
            end
        end
    endtask

    task automatic queue_expected(input bit byp);
        for (int r = EDGE; r < FRAME_H; r++) begin
            for (int c = EDGE; c < LINE_WIDTH; c++) begin
                if (byp) begin
                    exp_q.push_back(frame_pix[r-KERNEL_DIM/2][c-KERNEL_DIM/2]);
                end else begin
                    exp_q.push_back(median_of(r, c));
                end
            end
        end
    endtask

    //----------------------------------------------------------
    // stimulus
    //----------------------------------------------------------
    task automatic drive_cycle(input bit de, input bit vs, input pix_t pix, input bit byp);
        @(posedge clk);
        #DRIVE_DLY;
        de_i     = de;
        vs_i     = vs;
        di_i     = pix;
        bypass_i = byp;
    endtask

    task automatic send_frame(input bit byp, input bit toggle);
        int rnd;
        bit byp_now;
        byp_now = byp;
        drive_cycle(1'b0, 1'b1, '0, byp_now);
        vs_cyc_q.push_back(cyc);
        // mode reaches the output stage during this idle stretch
        repeat (VS_IDLE) drive_cycle(1'b0, 1'b0, '0, byp_now);
        for (int r = 0; r < FRAME_H; r++) begin
            // flipped request must not touch this frame
            if (toggle && r == FRAME_H / 2) begin
                byp_now = !byp;
            end
            for (int c = 0; c < LINE_WIDTH; c++) begin
                drive_cycle(1'b1, 1'b0, frame_pix[r][c], byp_now);
                if (r >= EDGE && c >= EDGE) begin
                    de_cyc_q.push_back(cyc);
                end
                rnd = $random(seed);
                if (rnd[1:0] == 2'b00) begin
                    drive_cycle(1'b0, 1'b0, '0, byp_now);
                end
            end
        end
    endtask

    initial begin
        seed     = 77000;
        done     = 1'b0;
        rst_i    = 1'b1;
        de_i     = 1'b0;
        vs_i     = 1'b0;
        di_i     = '0;
        bypass_i = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY rst_i = 1'b0;
        for (int f = 0; f < FRAMES; f++) begin
            build_frame(pattern_of[f]);
            queue_expected(bypass_of[f]);
            send_frame(bypass_of[f], toggle_of[f]);
        end
        drive_cycle(1'b0, 1'b0, '0, 1'b0);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        done = 1'b1;
    end

    //----------------------------------------------------------
    // checking
    //----------------------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout after %0d cycles, the output stream did not finish", cyc);
            $display("Errors found");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_i) begin
            if (vs_o) begin
                if (vs_cyc_q.size() == 0) begin
                    $display("vs_o seen without a frame start at the input");
                    errors++;
                end else begin
                    compare_value("vs_o latency", 32'(cyc - vs_cyc_q.pop_front()), LATENCY);
                end
                if (frames_seen > 0) begin
                    compare_value("de_o per frame", 32'(frame_cnt), PIX_PER_FRAME);
                end
                frames_seen++;
                frame_cnt = 0;
            end
            if (de_o) begin
                if (exp_q.size() == 0 || de_cyc_q.size() == 0) begin
                    $display("de_o seen with no output pixel expected");
                    errors++;
                end else begin
                    compare_value("do_o", 32'(do_o), 32'(exp_q.pop_front()));
                    compare_value("de_o latency", 32'(cyc - de_cyc_q.pop_front()), LATENCY);
                    checked++;
                end
                frame_cnt++;
            end
            if (done) begin
                compare_value("de_o per frame", 32'(frame_cnt), PIX_PER_FRAME);
                if (frames_seen != FRAMES || vs_cyc_q.size() != 0 || de_cyc_q.size() != 0) begin
                    $display("frame count wrong or accepted pixels never came out");
                    errors++;
                end
                $display("errors: %0d, pixels checked: %0d", errors, checked);
                if (errors == 0) begin
                    $display("No errors");
                end else begin
                    $display("Errors found");
                end
                $finish;
            end
        end
    end

endmodule

/* median_filter_5x5.f */
verilog/median_pkg.sv
verilog/window_builder.sv
verilog/sort_stage.sv
verilog/median_output.sv
verilog/median_filter_5x5.sv
tests/median_filter_props.sv
tests/median_filter_tb.sv

/* Makefile */
# Verilator build and run for the 5x5 median filter testbench

VERILATOR ?= verilator
TOP       ?= median_filter_tb
FILELIST  ?= median_filter_5x5.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
